// File: rtl/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

`define UART_DIV_W          16    // bit duration counter width
`define UART_ADDR_W         3     // register address width

//////////////////////////////////////////////////////////////////////
// register offsets
`define UART_ADDR_CTRL      3'd0  // soft_rst, tx_en, rx_en
`define UART_ADDR_DIV       3'd1  // cycles per bit
`define UART_ADDR_TXDATA    3'd2  // write only
`define UART_ADDR_RXDATA    3'd3  // read clears rx_ready
`define UART_ADDR_STATUS    3'd4  // tx_ready, rx_ready

`endif

// File: rtl/uart_pkg.sv
`include "uart_settings.svh"

package uart_pkg;

   typedef logic [`UART_DIV_W-1:0]  uart_div_t;   // bit duration in clocks
   typedef logic [7:0]              uart_byte_t;
   typedef logic [`UART_ADDR_W-1:0] uart_addr_t;

   typedef struct packed {
      logic        valid;   // single cycle strobe
      logic        we;
      uart_addr_t  addr;
      logic [15:0] wdata;
   } uart_bus_req_t;

   typedef struct packed {
      logic        rvalid;  // one cycle after the read
      logic [15:0] rdata;
   } uart_bus_rsp_t;

   typedef struct packed {
      logic soft_rst;
      logic tx_en;
      logic rx_en;
   } uart_ctrl_t;

   typedef enum logic [1:0] {TX_IDLE, TX_LOAD, TX_SEND} uart_tx_state_t;

   typedef enum logic [2:0] {
      RX_SYNC, RX_IDLE_HIGH, RX_WAIT_START, RX_START, RX_DATA
   } uart_rx_state_t;

endpackage

// File: rtl/uart_tx.sv
`timescale 1ns/1ns

module uart_tx (
   input  logic                 clk_i,
   input  logic                 arst_i,
   input  logic                 soft_rst_i,
   input  logic                 tx_en_i,
   input  logic                 cts_i,
   input  logic                 tx_wr_i,
   input  uart_pkg::uart_byte_t tx_data_i,
   input  uart_pkg::uart_div_t  bit_duration_i,
   output logic                 tx_ready_o,
   output logic                 txd_o
);

   import uart_pkg::*;

   logic [1:0]     cts_sync_q;   // two stage synchronizer
   logic           run;
   uart_tx_state_t state_q;
   logic [9:0]     pattern_q;    // {stop, data, start}, lsb goes out first
   logic [3:0]     bit_cnt_q;
   uart_div_t      cyc_cnt_q;

   //////////////////////////////////////////////////////////////////////
   // clear to send

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         cts_sync_q <= 2'b00;
      end else begin
         cts_sync_q <= {cts_sync_q[0], cts_i};
      end
   end

   assign run   = tx_en_i && cts_sync_q[1] && !soft_rst_i;
   assign txd_o = pattern_q[0];

   //////////////////////////////////////////////////////////////////////
   // frame sequencer

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         state_q    <= TX_IDLE;
         tx_ready_o <= 1'b0;
         pattern_q  <= '1;
         bit_cnt_q  <= '0;
         cyc_cnt_q  <= '0;
      end else if (!run) begin              // disabled, soft reset or cts low
         state_q    <= TX_IDLE;
         tx_ready_o <= 1'b0;
         pattern_q  <= '1;                  // line back to idle high
         bit_cnt_q  <= '0;
         cyc_cnt_q  <= '0;
      end else begin
         case (state_q)
            TX_IDLE: begin
               tx_ready_o <= !tx_wr_i;
               bit_cnt_q  <= '0;
               cyc_cnt_q  <= uart_div_t'(1);
               if (tx_wr_i) begin
                  state_q <= TX_LOAD;
               end
            end

            TX_LOAD: begin
               pattern_q <= {1'b1, tx_data_i, 1'b0};
               state_q   <= TX_SEND;
            end

            TX_SEND: begin
               if (cyc_cnt_q == bit_duration_i) begin
                  cyc_cnt_q <= uart_div_t'(1);
                  if (bit_cnt_q == 4'd9) begin       // stop bit done
                     state_q <= TX_IDLE;
                  end else begin
                     pattern_q <= {1'b1, pattern_q[9:1]};  // shift in idle ones
                     bit_cnt_q <= bit_cnt_q + 4'd1;
                  end
               end else begin
                  cyc_cnt_q <= cyc_cnt_q + uart_div_t'(1);
               end
            end

            default: begin
               state_q <= TX_IDLE;
            end
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // checks

   a_idle_line_high: assert property (
      @(posedge clk_i) disable iff (!arst_i)
      state_q == TX_IDLE |-> txd_o
   ) else $error("uart_tx: txd low while idle");

endmodule

// File: rtl/uart_rx.sv
`timescale 1ns/1ns

module uart_rx (
   input  logic                 clk_i,
   input  logic                 arst_i,
   input  logic                 soft_rst_i,
   input  logic                 rx_en_i,
   input  logic                 rxd_i,
   input  logic                 rx_rd_i,
   input  uart_pkg::uart_div_t  bit_duration_i,
   output uart_pkg::uart_byte_t rx_data_o,
   output logic                 rx_ready_o,
   output logic                 rts_o
);

   import uart_pkg::*;

   uart_rx_state_t state_q;
   uart_div_t      cyc_cnt_q;
   uart_div_t      half_bit;
   logic [3:0]     bit_cnt_q;
   uart_byte_t     pattern_q;     // data bits, lsb arrives first
   logic           rx_on;
   logic           bit_end;
   logic           sample;
   logic           latch;

   assign rx_on    = rx_en_i && !soft_rst_i;
   assign half_bit = bit_duration_i >> 1;
   assign bit_end  = (cyc_cnt_q == bit_duration_i);

   // data bit sample and stop slot strobes
   assign sample = rx_on && (state_q == RX_DATA) && bit_end && (bit_cnt_q != 4'd8);
   assign latch  = rx_on && (state_q == RX_DATA) && bit_end && (bit_cnt_q == 4'd8);

   //////////////////////////////////////////////////////////////////////
   // receive sequencer

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         state_q    <= RX_SYNC;
         cyc_cnt_q  <= uart_div_t'(1);
         bit_cnt_q  <= '0;
         rx_ready_o <= 1'b0;
         rts_o      <= 1'b0;
      end else if (!rx_on) begin
         state_q    <= RX_SYNC;
         cyc_cnt_q  <= uart_div_t'(1);
         bit_cnt_q  <= '0;
         rx_ready_o <= 1'b0;
         rts_o      <= 1'b0;
      end else begin
         rts_o <= 1'b1;                     // ready to accept data
         if (rx_rd_i) begin
            rx_ready_o <= 1'b0;             // a new byte below wins
         end

         case (state_q)
            RX_SYNC: begin
               cyc_cnt_q <= uart_div_t'(1);
               bit_cnt_q <= '0;
               if (rxd_i) begin
                  state_q <= RX_IDLE_HIGH;
               end
            end

            RX_IDLE_HIGH: begin
               cyc_cnt_q <= cyc_cnt_q + uart_div_t'(1);
               if (!rxd_i) begin
                  state_q <= RX_SYNC;       // line went low too early
               end else if (bit_end) begin
                  state_q <= RX_WAIT_START;
               end
            end

            RX_WAIT_START: begin
               cyc_cnt_q <= uart_div_t'(1);
               if (!rxd_i) begin
                  state_q <= RX_START;
               end
            end

            RX_START: begin
               if (cyc_cnt_q == half_bit) begin
                  cyc_cnt_q <= uart_div_t'(1);
                  // middle of the start bit must still be low
                  state_q   <= rxd_i ? RX_SYNC : RX_DATA;
               end else begin
                  cyc_cnt_q <= cyc_cnt_q + uart_div_t'(1);
               end
            end

            RX_DATA: begin
               if (bit_end) begin
                  cyc_cnt_q <= uart_div_t'(1);
                  if (bit_cnt_q == 4'd8) begin       // stop slot
                     rx_ready_o <= 1'b1;
                     bit_cnt_q  <= '0;
                     state_q    <= RX_WAIT_START;
                  end else begin
                     bit_cnt_q <= bit_cnt_q + 4'd1;
                  end
               end else begin
                  cyc_cnt_q <= cyc_cnt_q + uart_div_t'(1);
               end
            end

            default: begin
               state_q <= RX_SYNC;
            end
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // data path

   always_ff @(posedge clk_i) begin
      if (sample) begin
         pattern_q <= {rxd_i, pattern_q[7:1]};
      end
      if (latch) begin
         rx_data_o <= pattern_q;            // hand the byte to the cpu
      end
   end

   a_ready_needs_enable: assert property (
      @(posedge clk_i) disable iff (!arst_i)
      $rose(rx_ready_o) |-> rx_en_i
   ) else $error("uart_rx: rx_ready rose with receiver disabled");

endmodule

// File: rtl/uart_regs.sv
`timescale 1ns/1ns
`include "uart_settings.svh"

module uart_regs (
   input  logic                    clk_i,
   input  logic                    arst_i,
   input  uart_pkg::uart_bus_req_t bus_req_i,
   input  logic                    tx_ready_i,
   input  logic                    rx_ready_i,
   input  uart_pkg::uart_byte_t    rx_data_i,
   output uart_pkg::uart_bus_rsp_t bus_rsp_o,
   output uart_pkg::uart_ctrl_t    ctrl_o,
   output uart_pkg::uart_div_t     div_o,
   output uart_pkg::uart_byte_t    tx_data_o,
   output logic                    tx_wr_o,
   output logic                    rx_rd_o
);

   logic        wr;
   logic        rd;
   logic [15:0] rdata_d;
   logic        rvalid_q;
   logic [15:0] rdata_q;

   assign wr = bus_req_i.valid && bus_req_i.we;
   assign rd = bus_req_i.valid && !bus_req_i.we;

   // transmit write only goes through when the controller can take it
   assign tx_wr_o = wr && (bus_req_i.addr == `UART_ADDR_TXDATA) && tx_ready_i;
   assign rx_rd_o = rd && (bus_req_i.addr == `UART_ADDR_RXDATA);

   //////////////////////////////////////////////////////////////////////
   // write side

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         ctrl_o <= '0;
         div_o  <= '0;
      end else begin
         ctrl_o.soft_rst <= 1'b0;           // self clearing pulse
         if (wr && (bus_req_i.addr == `UART_ADDR_CTRL)) begin
            ctrl_o.soft_rst <= bus_req_i.wdata[0];
            ctrl_o.tx_en    <= bus_req_i.wdata[1];
            ctrl_o.rx_en    <= bus_req_i.wdata[2];
         end
         if (wr && (bus_req_i.addr == `UART_ADDR_DIV)) begin
            div_o <= bus_req_i.wdata[`UART_DIV_W-1:0];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (tx_wr_o) begin
         tx_data_o <= bus_req_i.wdata[7:0];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // read side

   always_comb begin
      case (bus_req_i.addr)
         `UART_ADDR_CTRL:   rdata_d = {13'd0, ctrl_o.rx_en, ctrl_o.tx_en, ctrl_o.soft_rst};
         `UART_ADDR_DIV:    rdata_d = 16'(div_o);
         `UART_ADDR_RXDATA: rdata_d = {8'd0, rx_data_i};
         `UART_ADDR_STATUS: rdata_d = {14'd0, rx_ready_i, tx_ready_i};
         default:           rdata_d = '0;      // txdata reads as zero
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_i) begin
      if (!arst_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd) begin
         rdata_q <= rdata_d;
      end
   end

   assign bus_rsp_o.rvalid = rvalid_q;
   assign bus_rsp_o.rdata  = rdata_q;

endmodule

// File: rtl/uart_core.sv
`timescale 1ns/1ns

module uart_core (
   input  logic                 clk_i,
   input  logic                 arst_i,
   input  uart_pkg::uart_ctrl_t ctrl_i,
   input  uart_pkg::uart_div_t  div_i,
   input  logic                 tx_wr_i,
   input  uart_pkg::uart_byte_t tx_data_i,
   input  logic                 rx_rd_i,
   input  logic                 rxd_i,
   input  logic                 cts_i,
   output logic                 tx_ready_o,
   output logic                 rx_ready_o,
   output uart_pkg::uart_byte_t rx_data_o,
   output logic                 txd_o,
   output logic                 rts_o
);

   import uart_pkg::*;

   uart_div_t div_eff;

   // keep half a bit above zero for the start check
   assign div_eff = (div_i < uart_div_t'(2)) ? uart_div_t'(2) : div_i;

   uart_tx u_tx (
      .clk_i          (clk_i),
      .arst_i         (arst_i),
      .soft_rst_i     (ctrl_i.soft_rst),
      .tx_en_i        (ctrl_i.tx_en),
      .cts_i          (cts_i),
      .tx_wr_i        (tx_wr_i),
      .tx_data_i      (tx_data_i),
      .bit_duration_i (div_eff),
      .tx_ready_o     (tx_ready_o),
      .txd_o          (txd_o)
   );

   uart_rx u_rx (
      .clk_i          (clk_i),
      .arst_i         (arst_i),
      .soft_rst_i     (ctrl_i.soft_rst),
      .rx_en_i        (ctrl_i.rx_en),
      .rxd_i          (rxd_i),
      .rx_rd_i        (rx_rd_i),
      .bit_duration_i (div_eff),
      .rx_data_o      (rx_data_o),
      .rx_ready_o     (rx_ready_o),
      .rts_o          (rts_o)
   );

   a_div_min: assert property (
      @(posedge clk_i) disable iff (!arst_i)
      (ctrl_i.tx_en || ctrl_i.rx_en) |-> (div_i >= uart_div_t'(2))
   ) else $error("uart_core: divisor below 2 while enabled");

endmodule

// File: rtl/uart_periph.sv
`timescale 1ns/1ns

module uart_periph (
   input  logic                    clk_i,
   input  logic                    arst_i,
   input  uart_pkg::uart_bus_req_t bus_req_i,
   output uart_pkg::uart_bus_rsp_t bus_rsp_o,
   input  logic                    rxd_i,
   input  logic                    cts_i,
   output logic                    txd_o,
   output logic                    rts_o
);

   import uart_pkg::*;

   uart_ctrl_t ctrl;
   uart_div_t  div;
   uart_byte_t tx_data;
   uart_byte_t rx_data;
   logic       tx_wr;
   logic       rx_rd;
   logic       tx_ready;
   logic       rx_ready;

   uart_regs u_regs (
      .clk_i      (clk_i),
      .arst_i     (arst_i),
      .bus_req_i  (bus_req_i),
      .tx_ready_i (tx_ready),
      .rx_ready_i (rx_ready),
      .rx_data_i  (rx_data),
      .bus_rsp_o  (bus_rsp_o),
      .ctrl_o     (ctrl),
      .div_o      (div),
      .tx_data_o  (tx_data),
      .tx_wr_o    (tx_wr),
      .rx_rd_o    (rx_rd)
   );

   uart_core u_core (
      .clk_i      (clk_i),
      .arst_i     (arst_i),
      .ctrl_i     (ctrl),
      .div_i      (div),
      .tx_wr_i    (tx_wr),
      .tx_data_i  (tx_data),
      .rx_rd_i    (rx_rd),
      .rxd_i      (rxd_i),
      .cts_i      (cts_i),
      .tx_ready_o (tx_ready),
      .rx_ready_o (rx_ready),
      .rx_data_o  (rx_data),
      .txd_o      (txd_o),
      .rts_o      (rts_o)
   );

endmodule

// File: tests/tb_uart_periph.sv
`timescale 1ns/1ns
`include "uart_settings.svh"

module tb_uart_periph;

   import uart_pkg::*;

   localparam int DIV         = 8;        // cycles per bit
   localparam int RSP_TIMEOUT = 8;        // cycles to wait for rvalid
   localparam int POLL_LIMIT  = 100;      // status reads before giving up

   logic          clk_i;
   logic          arst_i;
   uart_bus_req_t bus_req;
   uart_bus_rsp_t bus_rsp;
   logic          rxd;
   logic          cts;
   logic          txd;
   logic          rts;
   logic          loop_sel;               // 1 feeds txd back into rxd
   logic          rxd_force;              // crafted line level

   logic          rd_chk;
   logic [15:0]   rd_exp;
   logic [15:0]   rd_mask;
   logic          bit_chk;
   logic          bit_exp;
   logic          pin_chk;
   logic          exp_txd;
   logic          exp_rts;

   integer        seed;
   integer        rnd;
   int            err_cnt;
   int            err_start;
   int            pass_cnt;
   int            fail_cnt;
   int            i;
   string         test_name;
   uart_byte_t    data;

   assign rxd = loop_sel ? txd : rxd_force;

   always #20 clk_i = ~clk_i;

   uart_periph u_dut (
      .clk_i     (clk_i),
      .arst_i    (arst_i),
      .bus_req_i (bus_req),
      .bus_rsp_o (bus_rsp),
      .rxd_i     (rxd),
      .cts_i     (cts),
      .txd_o     (txd),
      .rts_o     (rts)
   );

   //////////////////////////////////////////////////////////////////////
   // checks

   // response comes exactly one cycle after each read request
   a_read_latency: assert property (
      @(posedge clk_i) disable iff (!arst_i)
      bus_rsp.rvalid == $past(bus_req.valid && !bus_req.we)
   ) else begin
      err_cnt++;
      $display("[ERROR] %s: rvalid expected %b actual %b", test_name,
               !$sampled(bus_rsp.rvalid), $sampled(bus_rsp.rvalid));
   end

   a_read_data: assert property (
      @(posedge clk_i) disable iff (!arst_i)
      (rd_chk && bus_rsp.rvalid) |-> ((bus_rsp.rdata & rd_mask) == rd_exp)
   ) else begin
      err_cnt++;
      $display("[ERROR] %s: read data expected %h actual %h", test_name,
               $sampled(rd_exp), $sampled(bus_rsp.rdata & rd_mask));
   end

   a_frame_bit: assert property (
      @(posedge clk_i) disable iff (!arst_i)
      bit_chk |-> (txd == bit_exp)
   ) else begin
      err_cnt++;
      $display("[ERROR] %s: txd expected %b actual %b", test_name,
               $sampled(bit_exp), $sampled(txd));
   end

   a_pins: assert property (
      @(posedge clk_i) disable iff (!arst_i)
      pin_chk |-> ((txd == exp_txd) && (rts == exp_rts))
   ) else begin
      err_cnt++;
      $display("[ERROR] %s: {txd,rts} expected %b actual %b", test_name,
               $sampled({exp_txd, exp_rts}), $sampled({txd, rts}));
   end

   //////////////////////////////////////////////////////////////////////
   // bus access

   task automatic write_reg(input uart_addr_t addr, input logic [15:0] wdata);
      uart_bus_req_t req;
      req.valid = 1'b1;
      req.we    = 1'b1;
      req.addr  = addr;
      req.wdata = wdata;
      @(posedge clk_i);
      bus_req <= req;
      @(posedge clk_i);
      bus_req <= '0;                      // write lands on this edge
   endtask

   task automatic read_reg(input uart_addr_t addr, input logic chk, input logic [15:0] exp_val,
                           input logic [15:0] mask, output logic [15:0] rdata);
      uart_bus_req_t req;
      int            n;
      req.valid = 1'b1;
      req.we    = 1'b0;
      req.addr  = addr;
      req.wdata = '0;
      n = 0;
      @(posedge clk_i);
      bus_req <= req;
      rd_chk  <= chk;
      rd_exp  <= exp_val;
      rd_mask <= mask;
      @(posedge clk_i);
      bus_req <= '0;
      @(negedge clk_i);
      while (!bus_rsp.rvalid && n < RSP_TIMEOUT) begin
         @(negedge clk_i);
         n++;
      end
      if (!bus_rsp.rvalid) begin
         $display("read of register %0d got no response within %0d cycles", addr, RSP_TIMEOUT);
         err_cnt++;
      end
      rdata = bus_rsp.rdata;
   endtask

   task automatic expect_reg(input uart_addr_t addr, input logic [15:0] exp_val,
                             input logic [15:0] mask);
      logic [15:0] rdata;
      read_reg(addr, 1'b1, exp_val & mask, mask, rdata);
   endtask

   task automatic wait_status(input int bit_idx);
      logic [15:0] st;
      int          n;
      st = '0;
      n  = 0;
      while (!st[bit_idx] && n < POLL_LIMIT) begin
         read_reg(`UART_ADDR_STATUS, 1'b0, '0, '0, st);
         n++;
      end
      if (!st[bit_idx]) begin
         $display("status bit %0d still clear after %0d polls", bit_idx, POLL_LIMIT);
         err_cnt++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // stimulus helpers

   task automatic pick_byte(output uart_byte_t b);
      rnd = $random(seed);
      b   = rnd[7:0];
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(posedge clk_i);
   endtask

   // pin check window opens on the next edge
   task automatic watch_pins(input logic txd_val, input logic rts_val, input int cycles);
      @(posedge clk_i);
      pin_chk <= 1'b1;
      exp_txd <= txd_val;
      exp_rts <= rts_val;
      repeat (cycles) @(posedge clk_i);
      pin_chk <= 1'b0;
   endtask

   // called on the edge that takes the TXDATA write
   task automatic follow_frame(input uart_byte_t b);
      logic [9:0] frame;
      int         c;
      frame   = {1'b1, b, 1'b0};              // stop, data, start
      bit_chk <= 1'b1;
      bit_exp <= 1'b1;                        // still idle one cycle after the write
      for (c = 1; c <= 10 * DIV; c++) begin
         @(posedge clk_i);
         if (c == 1) begin
            bit_exp <= 1'b0;                  // start bit two cycles after the write
         end else if (c % DIV == DIV / 2) begin
            bit_chk <= 1'b1;
            bit_exp <= frame[c / DIV];        // middle of bit c/DIV
         end else begin
            bit_chk <= 1'b0;
         end
      end
      bit_chk <= 1'b0;
   endtask

   task automatic send_receive(input uart_byte_t b);
      wait_status(0);
      write_reg(`UART_ADDR_TXDATA, {8'd0, b});
      wait_status(1);
      expect_reg(`UART_ADDR_RXDATA, {8'd0, b}, 16'h00ff);
   endtask

   task automatic open_test(input string name);
      test_name = name;
      err_start = err_cnt;
   endtask

   task automatic close_test();
      if (err_cnt == err_start) begin
         pass_cnt++;
         $display("test %s: pass", test_name);
      end else begin
         fail_cnt++;
         $display("test %s: fail", test_name);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // test sequence

   initial begin
      clk_i     = 1'b0;
      arst_i    = 1'b0;
      bus_req   = '0;
      cts       = 1'b1;
      loop_sel  = 1'b0;
      rxd_force = 1'b1;
      rd_chk    = 1'b0;
      rd_exp    = '0;
      rd_mask   = '0;
      bit_chk   = 1'b0;
      bit_exp   = 1'b1;
      pin_chk   = 1'b0;
      exp_txd   = 1'b1;
      exp_rts   = 1'b0;
      seed      = 32'h377e_269f;
      err_cnt   = 0;
      err_start = 0;
      pass_cnt  = 0;
      fail_cnt  = 0;
      test_name = "reset";

      repeat (3) @(posedge clk_i);
      arst_i   <= 1'b1;
      loop_sel <= 1'b1;                       // loopback from here on

      open_test("reset_state");
      watch_pins(1'b1, 1'b0, 1);
      expect_reg(`UART_ADDR_STATUS, 16'h0000, 16'hffff);
      write_reg(`UART_ADDR_DIV, 16'(DIV));
      expect_reg(`UART_ADDR_DIV, 16'(DIV), 16'hffff);
      write_reg(`UART_ADDR_CTRL, 16'h0004);   // rx only
      watch_pins(1'b1, 1'b1, 1);
      close_test();

      open_test("frame_format");
      write_reg(`UART_ADDR_CTRL, 16'h0006);
      wait_status(0);
      pick_byte(data);
      write_reg(`UART_ADDR_TXDATA, {8'd0, data});
      follow_frame(data);
      wait_status(1);
      expect_reg(`UART_ADDR_RXDATA, {8'd0, data}, 16'h00ff);
      close_test();

      open_test("loopback");
      for (i = 0; i < 4; i++) begin
         pick_byte(data);
         send_receive(data);
         expect_reg(`UART_ADDR_STATUS, 16'h0000, 16'h0002);
      end
      close_test();

      open_test("flow_control");
      @(posedge clk_i);
      cts <= 1'b0;
      idle_cycles(4);                         // let the synchronizer settle
      pick_byte(data);
      write_reg(`UART_ADDR_TXDATA, {8'd0, data});
      watch_pins(1'b1, 1'b1, 16);
      expect_reg(`UART_ADDR_STATUS, 16'h0000, 16'h0003);
      @(posedge clk_i);
      cts <= 1'b1;
      wait_status(0);
      expect_reg(`UART_ADDR_STATUS, 16'h0001, 16'h0003);  // blocked write never went out
      pick_byte(data);
      send_receive(data);
      close_test();

      open_test("false_start");
      @(posedge clk_i);
      loop_sel  <= 1'b0;
      rxd_force <= 1'b0;                      // glitch shorter than half a bit
      idle_cycles(DIV / 2 - 2);
      rxd_force <= 1'b1;
      idle_cycles(11 * DIV);                  // longer than a frame taken from the glitch
      expect_reg(`UART_ADDR_STATUS, 16'h0000, 16'h0002);
      @(posedge clk_i);
      loop_sel <= 1'b1;
      pick_byte(data);
      send_receive(data);
      close_test();

      open_test("soft_reset");
      pick_byte(data);
      wait_status(0);
      write_reg(`UART_ADDR_TXDATA, {8'd0, data});
      wait_status(1);
      wait_status(0);
      expect_reg(`UART_ADDR_STATUS, 16'h0002, 16'h0002);
      write_reg(`UART_ADDR_CTRL, 16'h0007);   // soft reset with both enables
      watch_pins(1'b1, 1'b0, 1);
      expect_reg(`UART_ADDR_STATUS, 16'h0000, 16'h0002);
      expect_reg(`UART_ADDR_CTRL, 16'h0006, 16'h0007);
      watch_pins(1'b1, 1'b1, 2);
      close_test();

      idle_cycles(2);
      $display("%0d passed, %0d failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// File: uart_periph.f
+incdir+rtl
rtl/uart_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_regs.sv
rtl/uart_core.sv
rtl/uart_periph.sv
tests/tb_uart_periph.sv

// File: Bender.yml
package:
  name: uart_periph

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/uart_pkg.sv
      - rtl/uart_tx.sv
      - rtl/uart_rx.sv
      - rtl/uart_regs.sv
      - rtl/uart_core.sv
      - rtl/uart_periph.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_uart_periph.sv
